/* compile.f */
logic/a2_card_pkg.sv
logic/bus_clock_sync.sv
logic/card_bus_arbiter.sv
logic/audio_mixer.sv
logic/status_leds.sv
logic/a2_card_top.sv
sim/a2_card_checker.sv
sim/a2_card_tb.sv

/* logic/a2_card_pkg.sv */
package a2_card_pkg;

    // Apple II data bus and card read data
    localparam int CARD_DATA_W = 8;

    // Card audio samples, unsigned
    localparam int CARD_AUDIO_W = 10;

    // Every audio source is widened to this before the sum
    localparam int MIX_EXT_W = 13;

    // Speaker bit lands on the top bit of the widened word
    localparam int SPEAKER_SHIFT = 12;

    // 10-bit card samples move up into the top of the widened word
    localparam int CARD_AUDIO_SHIFT = 3;

    // Signed mixer output word
    localparam int AUDIO_OUT_W = 16;

    // Output-enable switches for the bus drivers
    localparam logic BUS_DATA_OUT_ENABLE = 1'b1; // Card may drive D0-D7
    localparam logic IRQ_OUT_ENABLE = 1'b1;      // Card may pull IRQ low

    // Heartbeat period, half a second at the logic clock
    localparam logic [31:0] LED_PERIOD_CYCLES = 32'd10_000_000;

    // PHI1 and Q3 edge counters, LED shows the top bit
    localparam int EDGE_COUNT_W = 11;

    // ES5503 counter width and the bit shown while it runs
    localparam int ACTIVITY_COUNT_W = 16;
    localparam int ACTIVITY_LED_BIT = 8;

endpackage

/* logic/a2_card_top.sv */
`timescale 1ns/1ps

module a2_card_top #(
    parameter logic [31:0] led_period_cycles = a2_card_pkg::LED_PERIOD_CYCLES
) (
    input  logic                                        clk_logic_w,
    input  logic                                        system_reset_n_w,

    // Raw Apple II bus clocks
    input  logic                                        a2_phi1_i,
    input  logic                                        a2_q3_i,

    // Data bus and card read ports
    input  logic        [a2_card_pkg::CARD_DATA_W-1:0]  a2_d_i,
    input  logic                                        ssc_rd_i,
    input  logic        [a2_card_pkg::CARD_DATA_W-1:0]  ssc_d_i,
    input  logic                                        ssp_rd_i,
    input  logic        [a2_card_pkg::CARD_DATA_W-1:0]  ssp_d_i,
    input  logic                                        mb_rd_i,
    input  logic        [a2_card_pkg::CARD_DATA_W-1:0]  mb_d_i,

    // Card interrupts, active low
    input  logic                                        ssc_irq_n_i,
    input  logic                                        ssp_irq_n_i,
    input  logic                                        mb_irq_n_i,

    // Audio sources
    input  logic                                        speaker_i,
    input  logic        [a2_card_pkg::CARD_AUDIO_W-1:0] ssp_audio_i,
    input  logic        [a2_card_pkg::CARD_AUDIO_W-1:0] mb_audio_l_i,
    input  logic        [a2_card_pkg::CARD_AUDIO_W-1:0] mb_audio_r_i,

    input  logic [a2_card_pkg::ACTIVITY_COUNT_W-1:0]    es5503_count_i,

    output logic        [a2_card_pkg::CARD_DATA_W-1:0]  a2_d_o,
    output logic                                        a2_d_dir_o,
    output logic                                        a2_irq_n_o,
    output logic signed [a2_card_pkg::AUDIO_OUT_W-1:0]  audio_l_o,
    output logic signed [a2_card_pkg::AUDIO_OUT_W-1:0]  audio_r_o,
    output logic                                        led_heartbeat_o,
    output logic                                        led_phi1_o,
    output logic                                        led_2m_o
);

    logic phi1_rise_w;
    logic q3_rise_w;

    // PHI1 into the logic clock domain
    bus_clock_sync u_phi1_sync (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .async_i          (a2_phi1_i),
        .level_o          (),
        .rise_o           (phi1_rise_w),
        .fall_o           ()
    );

    // Q3 is the 2M clock
    bus_clock_sync u_q3_sync (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .async_i          (a2_q3_i),
        .level_o          (),
        .rise_o           (q3_rise_w),
        .fall_o           ()
    );

    card_bus_arbiter u_arbiter (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .a2_d_i           (a2_d_i),
        .ssc_rd_i         (ssc_rd_i),
        .ssc_d_i          (ssc_d_i),
        .ssp_rd_i         (ssp_rd_i),
        .ssp_d_i          (ssp_d_i),
        .mb_rd_i          (mb_rd_i),
        .mb_d_i           (mb_d_i),
        .ssc_irq_n_i      (ssc_irq_n_i),
        .ssp_irq_n_i      (ssp_irq_n_i),
        .mb_irq_n_i       (mb_irq_n_i),
        .a2_d_o           (a2_d_o),
        .a2_d_dir_o       (a2_d_dir_o),
        .a2_irq_n_o       (a2_irq_n_o)
    );

    audio_mixer u_mixer (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .speaker_i        (speaker_i),
        .ssp_audio_i      (ssp_audio_i),
        .mb_audio_l_i     (mb_audio_l_i),
        .mb_audio_r_i     (mb_audio_r_i),
        .audio_l_o        (audio_l_o),
        .audio_r_o        (audio_r_o)
    );

    status_leds #(
        .led_period_cycles (led_period_cycles)
    ) u_leds (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .phi1_rise_i      (phi1_rise_w),
        .q3_rise_i        (q3_rise_w),
        .es5503_count_i   (es5503_count_i),
        .led_heartbeat_o  (led_heartbeat_o),
        .led_phi1_o       (led_phi1_o),
        .led_2m_o         (led_2m_o)
    );

endmodule

/* logic/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer (
    input  logic                                        clk_logic_w,
    input  logic                                        system_reset_n_w,
    input  logic                                        speaker_i,
    input  logic        [a2_card_pkg::CARD_AUDIO_W-1:0] ssp_audio_i,
    input  logic        [a2_card_pkg::CARD_AUDIO_W-1:0] mb_audio_l_i,
    input  logic        [a2_card_pkg::CARD_AUDIO_W-1:0] mb_audio_r_i,
    output logic signed [a2_card_pkg::AUDIO_OUT_W-1:0]  audio_l_o,
    output logic signed [a2_card_pkg::AUDIO_OUT_W-1:0]  audio_r_o
);

    logic [a2_card_pkg::MIX_EXT_W-1:0]   spk_ext_w;
    logic [a2_card_pkg::MIX_EXT_W-1:0]   ssp_ext_w;
    logic [a2_card_pkg::MIX_EXT_W-1:0]   mb_l_ext_w;
    logic [a2_card_pkg::MIX_EXT_W-1:0]   mb_r_ext_w;
    logic [a2_card_pkg::AUDIO_OUT_W-1:0] sum_l_w;
    logic [a2_card_pkg::AUDIO_OUT_W-1:0] sum_r_w;

    // Speaker is a single full-scale bit
    always_comb begin
        spk_ext_w = '0;
        spk_ext_w[a2_card_pkg::SPEAKER_SHIFT] = speaker_i;
    end

    // Card samples move up to the top of the widened word
    assign ssp_ext_w  = {ssp_audio_i, {a2_card_pkg::CARD_AUDIO_SHIFT{1'b0}}};
    assign mb_l_ext_w = {mb_audio_l_i, {a2_card_pkg::CARD_AUDIO_SHIFT{1'b0}}};
    assign mb_r_ext_w = {mb_audio_r_i, {a2_card_pkg::CARD_AUDIO_SHIFT{1'b0}}};

    // Three 13-bit unsigned terms fit well below the 16-bit sign bit
    assign sum_l_w =
        {{(a2_card_pkg::AUDIO_OUT_W - a2_card_pkg::MIX_EXT_W){1'b0}}, ssp_ext_w} +
        {{(a2_card_pkg::AUDIO_OUT_W - a2_card_pkg::MIX_EXT_W){1'b0}}, mb_l_ext_w} +
        {{(a2_card_pkg::AUDIO_OUT_W - a2_card_pkg::MIX_EXT_W){1'b0}}, spk_ext_w};

    assign sum_r_w =
        {{(a2_card_pkg::AUDIO_OUT_W - a2_card_pkg::MIX_EXT_W){1'b0}}, ssp_ext_w} +
        {{(a2_card_pkg::AUDIO_OUT_W - a2_card_pkg::MIX_EXT_W){1'b0}}, mb_r_ext_w} +
        {{(a2_card_pkg::AUDIO_OUT_W - a2_card_pkg::MIX_EXT_W){1'b0}}, spk_ext_w};

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= $signed(sum_l_w); // One sample per cycle, no stall
            audio_r_o <= $signed(sum_r_w);
        end
    end

    // All sources are unsigned, so the mix can never go negative
    a_mix_non_negative: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        !audio_l_o[a2_card_pkg::AUDIO_OUT_W-1] && !audio_r_o[a2_card_pkg::AUDIO_OUT_W-1]
    );

endmodule

/* logic/bus_clock_sync.sv */
`timescale 1ns/1ps

module bus_clock_sync (
    input  logic clk_logic_w,
    input  logic system_reset_n_w,
    input  logic async_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    logic [1:0] sync_q;   // Two-flop synchronizer, bit 1 is the stable one
    logic       filt_q;   // Previous synchronized sample
    logic       level_next_w;

    // Level only moves when two synchronized samples agree
    assign level_next_w = (sync_q[1] == filt_q) ? filt_q : level_o;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            sync_q  <= 2'b00;
            filt_q  <= 1'b0;
            level_o <= 1'b0;
            rise_o  <= 1'b0;
            fall_o  <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], async_i};
            filt_q  <= sync_q[1];
            level_o <= level_next_w;
            rise_o  <= level_next_w & ~level_o;  // Aligned with the level change
            fall_o  <= ~level_next_w & level_o;
        end
    end

    // The agreement filter keeps level changes at least two cycles apart
    a_edge_spacing: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        (rise_o || fall_o) |=> !(rise_o || fall_o)
    );

endmodule

/* logic/card_bus_arbiter.sv */
`timescale 1ns/1ps

module card_bus_arbiter (
    input  logic                                clk_logic_w,
    input  logic                                system_reset_n_w,
    input  logic [a2_card_pkg::CARD_DATA_W-1:0] a2_d_i,
    input  logic                                ssc_rd_i,
    input  logic [a2_card_pkg::CARD_DATA_W-1:0] ssc_d_i,
    input  logic                                ssp_rd_i,
    input  logic [a2_card_pkg::CARD_DATA_W-1:0] ssp_d_i,
    input  logic                                mb_rd_i,
    input  logic [a2_card_pkg::CARD_DATA_W-1:0] mb_d_i,
    input  logic                                ssc_irq_n_i,
    input  logic                                ssp_irq_n_i,
    input  logic                                mb_irq_n_i,
    output logic [a2_card_pkg::CARD_DATA_W-1:0] a2_d_o,
    output logic                                a2_d_dir_o,
    output logic                                a2_irq_n_o
);

    logic any_rd_w;
    logic irq_n_w;

    assign any_rd_w = ssc_rd_i | ssp_rd_i | mb_rd_i;

    // SuperSerial wins, then SuperSprite, then Mockingboard
    always_comb begin
        if (ssc_rd_i) begin
            a2_d_o = ssc_d_i;
        end else if (ssp_rd_i) begin
            a2_d_o = ssp_d_i;
        end else if (mb_rd_i) begin
            a2_d_o = mb_d_i;
        end else begin
            a2_d_o = a2_d_i; // Nobody reads, echo the latched bus
        end
    end

    // High turns the level shifter toward the Apple II
    assign a2_d_dir_o = any_rd_w & a2_card_pkg::BUS_DATA_OUT_ENABLE;

    // Wired-AND of the active-low card interrupts
    assign irq_n_w = ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i;
    assign a2_irq_n_o = a2_card_pkg::IRQ_OUT_ENABLE ? irq_n_w : 1'b1;

    // A driven bus always carries the byte of a card that is being read
    a_dir_drives_card_data: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        a2_d_dir_o |-> ((ssc_rd_i && a2_d_o == ssc_d_i)
                     || (ssp_rd_i && a2_d_o == ssp_d_i)
                     || (mb_rd_i && a2_d_o == mb_d_i))
    );

endmodule

/* logic/status_leds.sv */
`timescale 1ns/1ps

module status_leds #(
    parameter logic [31:0] led_period_cycles = a2_card_pkg::LED_PERIOD_CYCLES
) (
    input  logic                                     clk_logic_w,
    input  logic                                     system_reset_n_w,
    input  logic                                     phi1_rise_i,
    input  logic                                     q3_rise_i,
    input  logic [a2_card_pkg::ACTIVITY_COUNT_W-1:0] es5503_count_i,
    output logic                                     led_heartbeat_o,
    output logic                                     led_phi1_o,
    output logic                                     led_2m_o
);

    logic [31:0]                              period_cnt_q;
    logic                                     period_end_w;
    logic [a2_card_pkg::ACTIVITY_COUNT_W-1:0] es_prev_q;
    logic                                     activity_q;
    logic                                     activity_seen_w;
    logic [a2_card_pkg::EDGE_COUNT_W-1:0]     phi1_cnt_q;
    logic [a2_card_pkg::EDGE_COUNT_W-1:0]     q3_cnt_q;

    assign period_end_w = (period_cnt_q == led_period_cycles - 32'd1);

    // Count as it was one cycle ago
    always_ff @(posedge clk_logic_w) begin
        es_prev_q <= es5503_count_i;
    end

    // Includes a change in the very cycle of the update
    assign activity_seen_w = activity_q | (es5503_count_i != es_prev_q);

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            period_cnt_q    <= '0;
            activity_q      <= 1'b0;
            led_heartbeat_o <= 1'b0;
        end else if (period_end_w) begin
            period_cnt_q <= '0;
            activity_q   <= 1'b0;
            if (activity_seen_w) begin
                led_heartbeat_o <= es5503_count_i[a2_card_pkg::ACTIVITY_LED_BIT];
            end else begin
                led_heartbeat_o <= ~led_heartbeat_o; // Idle heartbeat
            end
        end else begin
            period_cnt_q <= period_cnt_q + 32'd1;
            activity_q   <= activity_seen_w;
        end
    end

    // Bus clock activity, one LED toggle per 1024 rising edges
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            phi1_cnt_q <= '0;
            q3_cnt_q   <= '0;
        end else begin
            if (phi1_rise_i) begin
                phi1_cnt_q <= phi1_cnt_q + 1'b1;
            end
            if (q3_rise_i) begin
                q3_cnt_q <= q3_cnt_q + 1'b1;
            end
        end
    end

    assign led_phi1_o = phi1_cnt_q[a2_card_pkg::EDGE_COUNT_W-1];
    assign led_2m_o   = q3_cnt_q[a2_card_pkg::EDGE_COUNT_W-1];

    a_period_in_range: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        period_cnt_q < led_period_cycles
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module a2_card_tb \
    -o a2_card_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/a2_card_sim > sim.log 2>&1
cat sim.log

grep -qx "Done: no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* sim/a2_card_checker.sv */
`timescale 1ns/1ps

module a2_card_checker (
    input logic                                       a2_phi1_i,
    input logic                                       a2_q3_i,
    input logic        [a2_card_pkg::CARD_DATA_W-1:0] a2_d_i,
    input logic        [a2_card_pkg::CARD_DATA_W-1:0] ssc_d_i,
    input logic        [a2_card_pkg::CARD_DATA_W-1:0] ssp_d_i,
    input logic        [a2_card_pkg::CARD_DATA_W-1:0] mb_d_i,
    input logic                                       ssc_rd_i,
    input logic                                       ssp_rd_i,
    input logic                                       mb_rd_i,
    input logic                                       speaker_i,
    input logic       [a2_card_pkg::CARD_AUDIO_W-1:0] ssp_audio_i,
    input logic       [a2_card_pkg::CARD_AUDIO_W-1:0] mb_audio_l_i,
    input logic       [a2_card_pkg::CARD_AUDIO_W-1:0] mb_audio_r_i,
    input logic        [a2_card_pkg::CARD_DATA_W-1:0] a2_d_o,
    input logic                                       a2_d_dir_o,
    input logic                                       a2_irq_n_o,
    input logic signed [a2_card_pkg::AUDIO_OUT_W-1:0] audio_l_o,
    input logic signed [a2_card_pkg::AUDIO_OUT_W-1:0] audio_r_o,
    input logic                                       led_heartbeat_o,
    input logic                                       led_phi1_o,
    input logic                                       led_2m_o
);

    int total_checks = 0;
    int err_cnt = 0;
    int test_checks = 0;
    int test_errs = 0;
    int phi1_rises = 0;   // Raw PHI1 rising edges seen at the DUT input
    int q3_rises = 0;
    int hb_changes = 0;
    int hb_start = 0;

    always @(posedge a2_phi1_i) begin
        phi1_rises++;
    end

    always @(posedge a2_q3_i) begin
        q3_rises++;
    end

    // Every change of the heartbeat LED, counted as it happens
    always @(led_heartbeat_o) begin
        hb_changes++;
    end

    task automatic record_check(input logic ok, input string msg);
        total_checks++;
        test_checks++;
        if (!ok) begin
            err_cnt++;
            test_errs++;
            $display("FAIL at %0d ns: %s", $time, msg);
        end
    endtask

    task automatic check_after_reset();
        record_check(a2_d_dir_o == 1'b0, "a2_d_dir_o not low after reset");
        record_check(a2_irq_n_o == 1'b1, "a2_irq_n_o not high after reset");
        record_check(audio_l_o == '0 && audio_r_o == '0, "audio outputs not zero after reset");
        record_check({led_heartbeat_o, led_phi1_o, led_2m_o} == 3'b000,
                     "LEDs not off after reset");
    endtask

    // Read priority is SuperSerial, SuperSprite, Mockingboard, then bus echo
    task automatic check_bus();
        logic [2:0]                          strobes;
        logic [a2_card_pkg::CARD_DATA_W-1:0] exp_d;
        logic                                exp_dir;
        strobes = {ssc_rd_i, ssp_rd_i, mb_rd_i};
        casez (strobes)
            3'b1??:  exp_d = ssc_d_i;
            3'b01?:  exp_d = ssp_d_i;
            3'b001:  exp_d = mb_d_i;
            default: exp_d = a2_d_i;
        endcase
        exp_dir = (strobes != 3'b000) && a2_card_pkg::BUS_DATA_OUT_ENABLE;
        record_check(a2_d_o == exp_d, $sformatf("a2_d_o %02h, expected %02h with strobes %b",
                     a2_d_o, exp_d, strobes));
        record_check(a2_d_dir_o == exp_dir,
                     $sformatf("a2_d_dir_o %b, expected %b", a2_d_dir_o, exp_dir));
    endtask

    task automatic check_irq(input logic exp_irq_n);
        record_check(a2_irq_n_o == exp_irq_n,
                     $sformatf("a2_irq_n_o %b, expected %b", a2_irq_n_o, exp_irq_n));
    endtask

    task automatic check_mix();
        int spk_w;
        int exp_l;
        int exp_r;
        spk_w = int'(speaker_i) << a2_card_pkg::SPEAKER_SHIFT;
        exp_l = spk_w + (int'(ssp_audio_i) << a2_card_pkg::CARD_AUDIO_SHIFT)
              + (int'(mb_audio_l_i) << a2_card_pkg::CARD_AUDIO_SHIFT);
        exp_r = spk_w + (int'(ssp_audio_i) << a2_card_pkg::CARD_AUDIO_SHIFT)
              + (int'(mb_audio_r_i) << a2_card_pkg::CARD_AUDIO_SHIFT);
        record_check(int'(audio_l_o) == exp_l,
                     $sformatf("audio_l_o %0d, expected %0d", audio_l_o, exp_l));
        record_check(int'(audio_r_o) == exp_r,
                     $sformatf("audio_r_o %0d, expected %0d", audio_r_o, exp_r));
    endtask

    // One LED toggle per 1024 rises
    task automatic check_clock_leds(input logic exp_phi1, input logic exp_2m);
        logic rule_phi1;
        logic rule_2m;
        rule_phi1 = ((phi1_rises / 1024) % 2) == 1;
        rule_2m   = ((q3_rises / 1024) % 2) == 1;
        record_check(led_phi1_o == exp_phi1 && exp_phi1 == rule_phi1,
                     $sformatf("led_phi1_o %b after %0d PHI1 rises, expected %b",
                     led_phi1_o, phi1_rises, exp_phi1));
        record_check(led_2m_o == exp_2m && exp_2m == rule_2m,
                     $sformatf("led_2m_o %b after %0d Q3 rises, expected %b",
                     led_2m_o, q3_rises, exp_2m));
    endtask

    task automatic start_hb_window();
        hb_start = hb_changes;
    endtask

    task automatic check_hb_changes(input int exp_changes);
        record_check(hb_changes - hb_start == exp_changes,
                     $sformatf("heartbeat changed %0d times, expected %0d",
                     hb_changes - hb_start, exp_changes));
    endtask

    task automatic check_hb_level(input logic exp_level);
        record_check(led_heartbeat_o == exp_level,
                     $sformatf("led_heartbeat_o %b, expected %b", led_heartbeat_o, exp_level));
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic report_totals();
        $display("All tests: %0d checks, %0d errors", total_checks, err_cnt);
    endtask

endmodule

/* sim/a2_card_tb.sv */
`timescale 1ns/1ps

module a2_card_tb;

    localparam int ARB_ROWS = 8;
    localparam int IRQ_ROWS = 8;
    localparam int MIX_ROWS = 12;
    localparam int CLK_ROWS = 3;
    localparam int CLK_PERIODS = 1024;  // Bus clock periods per row
    localparam int CLK_HOLD = 6;        // Cycles per bus clock level
    localparam int HB_ROWS = 3;
    localparam int TEST_CYCLES = ARB_ROWS + IRQ_ROWS + MIX_ROWS * 2
                               + CLK_ROWS * CLK_PERIODS * CLK_HOLD * 2 + 640 + 64 * 2;
    localparam int TIMEOUT_CYCLES = (TEST_CYCLES + 8) * 11 / 10;

    logic        clk_logic_w;
    logic        system_reset_n_w;
    logic        a2_phi1_i;
    logic        a2_q3_i;
    logic [7:0]  a2_d_i;
    logic        ssc_rd_i;
    logic [7:0]  ssc_d_i;
    logic        ssp_rd_i;
    logic [7:0]  ssp_d_i;
    logic        mb_rd_i;
    logic [7:0]  mb_d_i;
    logic        ssc_irq_n_i;
    logic        ssp_irq_n_i;
    logic        mb_irq_n_i;
    logic        speaker_i;
    logic [9:0]  ssp_audio_i;
    logic [9:0]  mb_audio_l_i;
    logic [9:0]  mb_audio_r_i;
    logic [15:0] es5503_count_i;
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;

    // Stimulus and expected tables
    logic [2:0]  arb_rd [ARB_ROWS];     // {ssc, ssp, mb} strobes
    logic [7:0]  arb_bus [ARB_ROWS];
    logic [7:0]  arb_ssc [ARB_ROWS];
    logic [7:0]  arb_ssp [ARB_ROWS];
    logic [7:0]  arb_mb [ARB_ROWS];
    logic [2:0]  irq_in [IRQ_ROWS];     // {ssc, ssp, mb} active low
    logic        irq_exp [IRQ_ROWS];
    logic        mix_spk [MIX_ROWS];
    logic [9:0]  mix_ssp [MIX_ROWS];
    logic [9:0]  mix_l [MIX_ROWS];
    logic [9:0]  mix_r [MIX_ROWS];
    logic        clk_sel [CLK_ROWS] = '{1'b0, 1'b0, 1'b1};      // High selects Q3
    logic        clk_exp_phi1 [CLK_ROWS] = '{1'b1, 1'b0, 1'b0};
    logic        clk_exp_2m [CLK_ROWS] = '{1'b0, 1'b0, 1'b1};
    // Two active rows in a row, both with bit 8 set, so an idle toggle cannot match both
    logic [15:0] hb_count [HB_ROWS] = '{16'h0000, 16'h0155, 16'h01aa};
    int          hb_cycles [HB_ROWS] = '{640, 64, 64};
    logic        hb_level_mode [HB_ROWS] = '{1'b0, 1'b1, 1'b1};   // Low counts LED changes
    int          hb_exp [HB_ROWS] = '{10, 1, 1};

    a2_card_top #(
        .led_period_cycles (32'd64)
    ) UUT (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .a2_phi1_i        (a2_phi1_i),
        .a2_q3_i          (a2_q3_i),
        .a2_d_i           (a2_d_i),
        .ssc_rd_i         (ssc_rd_i),
        .ssc_d_i          (ssc_d_i),
        .ssp_rd_i         (ssp_rd_i),
        .ssp_d_i          (ssp_d_i),
        .mb_rd_i          (mb_rd_i),
        .mb_d_i           (mb_d_i),
        .ssc_irq_n_i      (ssc_irq_n_i),
        .ssp_irq_n_i      (ssp_irq_n_i),
        .mb_irq_n_i       (mb_irq_n_i),
        .speaker_i        (speaker_i),
        .ssp_audio_i      (ssp_audio_i),
        .mb_audio_l_i     (mb_audio_l_i),
        .mb_audio_r_i     (mb_audio_r_i),
        .es5503_count_i   (es5503_count_i),
        .a2_d_o           (),
        .a2_d_dir_o       (),
        .a2_irq_n_o       (),
        .audio_l_o        (),
        .audio_r_o        (),
        .led_heartbeat_o  (),
        .led_phi1_o       (),
        .led_2m_o         ()
    );

    a2_card_checker u_checker (
        .a2_phi1_i        (UUT.a2_phi1_i),
        .a2_q3_i          (UUT.a2_q3_i),
        .a2_d_i           (UUT.a2_d_i),
        .ssc_d_i          (UUT.ssc_d_i),
        .ssp_d_i          (UUT.ssp_d_i),
        .mb_d_i           (UUT.mb_d_i),
        .ssc_rd_i         (UUT.ssc_rd_i),
        .ssp_rd_i         (UUT.ssp_rd_i),
        .mb_rd_i          (UUT.mb_rd_i),
        .speaker_i        (UUT.speaker_i),
        .ssp_audio_i      (UUT.ssp_audio_i),
        .mb_audio_l_i     (UUT.mb_audio_l_i),
        .mb_audio_r_i     (UUT.mb_audio_r_i),
        .a2_d_o           (UUT.a2_d_o),
        .a2_d_dir_o       (UUT.a2_d_dir_o),
        .a2_irq_n_o       (UUT.a2_irq_n_o),
        .audio_l_o        (UUT.audio_l_o),
        .audio_r_o        (UUT.audio_r_o),
        .led_heartbeat_o  (UUT.led_heartbeat_o),
        .led_phi1_o       (UUT.led_phi1_o),
        .led_2m_o         (UUT.led_2m_o)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #50 clk_logic_w = ~clk_logic_w;
    end

    // Run limit derived from the table lengths
    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle();
        @(posedge clk_logic_w);
        #10;  // Inputs change just after the edge
    endtask

    task automatic fill_tables();
        for (int i = 0; i < ARB_ROWS; i++) begin
            arb_rd[i]  = i[2:0];
            lcg_state  = lcg_next(lcg_state);
            arb_bus[i] = lcg_state[31:24];
            arb_ssc[i] = lcg_state[23:16];
            arb_ssp[i] = lcg_state[15:8];
            lcg_state  = lcg_next(lcg_state);
            arb_mb[i]  = lcg_state[31:24];
        end
        for (int i = 0; i < IRQ_ROWS; i++) begin
            irq_in[i]  = i[2:0];
            irq_exp[i] = a2_card_pkg::IRQ_OUT_ENABLE ? &irq_in[i] : 1'b1;
        end
        for (int i = 0; i < MIX_ROWS; i++) begin
            lcg_state  = lcg_next(lcg_state);
            mix_spk[i] = lcg_state[31];
            mix_ssp[i] = lcg_state[30:21];
            mix_l[i]   = lcg_state[20:11];
            mix_r[i]   = lcg_state[10:1];
        end
        mix_spk[0] = 1'b1;  // Full-scale corner
        mix_ssp[0] = '1;
        mix_l[0]   = '1;
        mix_r[0]   = '1;
        mix_spk[1] = 1'b0;
        mix_ssp[1] = '0;
        mix_l[1]   = '0;
        mix_r[1]   = '0;
    endtask

    initial begin
        lcg_state        = 32'h4fcb;
        system_reset_n_w = 1'b0;
        a2_phi1_i        = 1'b0;
        a2_q3_i          = 1'b0;
        a2_d_i           = '0;
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b000;
        ssc_d_i          = '0;
        ssp_d_i          = '0;
        mb_d_i           = '0;
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        speaker_i        = 1'b0;
        ssp_audio_i      = '0;
        mb_audio_l_i     = '0;
        mb_audio_r_i     = '0;
        es5503_count_i   = '0;
        fill_tables();

        repeat (8) @(posedge clk_logic_w);
        #10;
        system_reset_n_w = 1'b1;
        u_checker.check_after_reset();
        u_checker.end_test("reset");

        for (int i = 0; i < ARB_ROWS; i++) begin
            next_cycle();
            {ssc_rd_i, ssp_rd_i, mb_rd_i} = arb_rd[i];
            a2_d_i  = arb_bus[i];
            ssc_d_i = arb_ssc[i];
            ssp_d_i = arb_ssp[i];
            mb_d_i  = arb_mb[i];
            #40;
            u_checker.check_bus();
        end
        next_cycle();
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b000;
        u_checker.end_test("arbiter");

        for (int i = 0; i < IRQ_ROWS; i++) begin
            next_cycle();
            {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = irq_in[i];
            #40;
            u_checker.check_irq(irq_exp[i]);
        end
        next_cycle();
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        u_checker.end_test("interrupt");

        for (int i = 0; i < MIX_ROWS; i++) begin
            speaker_i    = mix_spk[i];
            ssp_audio_i  = mix_ssp[i];
            mb_audio_l_i = mix_l[i];
            mb_audio_r_i = mix_r[i];
            next_cycle();
            next_cycle();
            u_checker.check_mix();
        end
        u_checker.end_test("mixer");

        for (int r = 0; r < CLK_ROWS; r++) begin
            for (int p = 0; p < CLK_PERIODS; p++) begin
                if (clk_sel[r]) begin
                    a2_q3_i = 1'b1;
                end else begin
                    a2_phi1_i = 1'b1;
                end
                repeat (CLK_HOLD) next_cycle();
                a2_q3_i   = 1'b0;
                a2_phi1_i = 1'b0;
                repeat (CLK_HOLD) next_cycle();
            end
            u_checker.check_clock_leds(clk_exp_phi1[r], clk_exp_2m[r]);
        end
        u_checker.end_test("bus_clock_leds");

        for (int r = 0; r < HB_ROWS; r++) begin
            u_checker.start_hb_window();
            es5503_count_i = hb_count[r];
            repeat (hb_cycles[r]) next_cycle();
            if (hb_level_mode[r]) begin
                u_checker.check_hb_level(hb_exp[r] != 0);
            end else begin
                u_checker.check_hb_changes(hb_exp[r]);
            end
        end
        u_checker.end_test("heartbeat");

        u_checker.report_totals();
        if (u_checker.err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
